//--- Bender.yml
package:
  name: mc_mapper

sources:
  - hdl/mc_pkg.sv
  - hdl/addr_mapper.sv
  - hdl/hold_register.sv
  - hdl/tag_counter.sv
  - hdl/req_sequencer.sv
  - hdl/bank_dispatch.sv
  - hdl/mc_mapper_top.sv
  - target: test
    files:
      - verification/mc_mapper_checker.sv
      - verification/mc_mapper_tb.sv

//--- filelist.f
hdl/mc_pkg.sv
hdl/addr_mapper.sv
hdl/hold_register.sv
hdl/tag_counter.sv
hdl/req_sequencer.sv
hdl/bank_dispatch.sv
hdl/mc_mapper_top.sv
verification/mc_mapper_checker.sv
verification/mc_mapper_tb.sv

//--- hdl/addr_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module addr_mapper import mc_pkg::*; (
	input wire addr_t in_addr,
	output bg_t bg,
	output bank_t bank,
	output row_t row,
	output col_t col,
	output bank_idx_t bank_idx
);

	bg_t hash_bg; // high address bits folded into bank group
	bank_t hash_bank; // high address bits folded into bank

	// Layout of the raw word address, msb first:
	// row(16) bank(2) col_hi(6) bg(2) col_lo(4)
	always_comb begin
		hash_bg = in_addr[HASH_BG_LO +: BG_W];
		hash_bank = in_addr[HASH_BANK_LO +: BANK_W];
	end

	always_comb begin
		bg = in_addr[5:4] ^ hash_bg;
		bank = in_addr[13:12] ^ hash_bank; // spreads rows over banks
		row = in_addr[29:14];
		col = {in_addr[11:6], in_addr[3:0]}; // split column rejoined
	end

	assign bank_idx = {bg, bank}; // group in the upper bits

endmodule

`default_nettype wire

//--- hdl/bank_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module bank_dispatch import mc_pkg::*; (
	input wire issue,
	input wire req_type_t held_type,
	input wire data_t held_data,
	input wire bg_t held_bg,
	input wire bank_t held_bank,
	input wire row_t held_row,
	input wire col_t held_col,
	input wire bank_idx_t held_idx,
	input wire tag_t tag,
	output logic array_enable,
	output req_type_t array_type,
	output bg_t array_bg,
	output bank_t array_bank,
	output row_t array_row,
	output col_t array_col,
	output data_t array_data,
	output tag_t array_index,
	output logic [NUM_BANKS-1:0] bank_valid,
	output bank_word_t bank_req
);

	always_comb begin
		array_enable = issue;
		array_type = issue ? held_type : req_read;
		array_bg = issue ? held_bg : '0;
		array_bank = issue ? held_bank : '0;
		array_row = issue ? held_row : '0;
		array_col = issue ? held_col : '0;
		array_index = issue ? tag : '0;
		// reads carry no payload
		array_data = (issue && held_type == req_write) ? held_data : '0;
	end

	always_comb begin
		for (int i = 0; i < NUM_BANKS; i++) begin
			bank_valid[i] = issue && (held_idx == bank_idx_t'(i)); // one hot decode
		end
	end

	always_comb begin
		if (issue) begin
			bank_req = {tag, held_type, held_row}; // shared bus for all banks
		end else begin
			bank_req = '0;
		end
	end

endmodule

`default_nettype wire

//--- hdl/hold_register.sv
`timescale 1ns/1ps
`default_nettype none

module hold_register import mc_pkg::*; (
	input wire clk,
	input wire rst,
	input wire load,
	input wire clear,
	input wire req_type_t in_type,
	input wire data_t in_data,
	input wire bg_t bg,
	input wire bank_t bank,
	input wire row_t row,
	input wire col_t col,
	input wire bank_idx_t bank_idx,
	output logic held_valid,
	output req_type_t held_type,
	output data_t held_data,
	output bg_t held_bg,
	output bank_t held_bank,
	output row_t held_row,
	output col_t held_col,
	output bank_idx_t held_idx
);

	always_ff @(posedge clk) begin
		if (rst) begin
			held_valid <= 1'b0;
		end else if (load) begin
			held_valid <= 1'b1; // a load wins over a same cycle issue
		end else if (clear) begin
			held_valid <= 1'b0;
		end
	end

	// captured already mapped, so the dispatch path has no hash logic
	always_ff @(posedge clk) begin
		if (load) begin
			held_type <= in_type;
			held_data <= in_data;
			held_bg <= bg;
			held_bank <= bank;
			held_row <= row;
			held_col <= col;
			held_idx <= bank_idx;
		end
	end

endmodule

`default_nettype wire

//--- hdl/mc_mapper_top.sv
`timescale 1ns/1ps
`default_nettype none

module mc_mapper_top import mc_pkg::*; (
	input wire clk,
	input wire rst,
	input wire in_valid, // from host
	input wire req_type_t in_type,
	input wire addr_t in_addr,
	input wire data_t in_data,
	output logic out_busy, // to host
	input wire stop_reading, // from global array
	input wire stop_writing,
	output logic array_enable, // to global array
	output req_type_t array_type,
	output bg_t array_bg,
	output bank_t array_bank,
	output row_t array_row,
	output col_t array_col,
	output data_t array_data,
	output tag_t array_index,
	input wire [NUM_BANKS-1:0] bank_busy, // from banks
	output logic [NUM_BANKS-1:0] bank_valid, // to banks
	output bank_word_t bank_req
);

	bg_t map_bg;
	bank_t map_bank;
	row_t map_row;
	col_t map_col;
	bank_idx_t map_idx;

	logic held_valid;
	req_type_t held_type;
	data_t held_data;
	bg_t held_bg;
	bank_t held_bank;
	row_t held_row;
	col_t held_col;
	bank_idx_t held_idx;

	logic load;
	logic issue;
	tag_t tag;

	addr_mapper u_mapper (
		.in_addr(in_addr), .bg(map_bg), .bank(map_bank), .row(map_row),
		.col(map_col), .bank_idx(map_idx)
	);

	hold_register u_hold (
		.clk(clk), .rst(rst), .load(load), .clear(issue),
		.in_type(in_type), .in_data(in_data),
		.bg(map_bg), .bank(map_bank), .row(map_row), .col(map_col), .bank_idx(map_idx),
		.held_valid(held_valid), .held_type(held_type), .held_data(held_data),
		.held_bg(held_bg), .held_bank(held_bank), .held_row(held_row),
		.held_col(held_col), .held_idx(held_idx)
	);

	req_sequencer u_seq (
		.clk(clk), .rst(rst), .in_valid(in_valid),
		.held_valid(held_valid), .held_type(held_type), .held_idx(held_idx),
		.stop_reading(stop_reading), .stop_writing(stop_writing), .bank_busy(bank_busy),
		.load(load), .issue(issue), .out_busy(out_busy)
	);

	tag_counter u_tags (
		.clk(clk), .rst(rst), .advance(issue), .adv_type(held_type), .tag(tag)
	);

	bank_dispatch u_dispatch (
		.issue(issue), .held_type(held_type), .held_data(held_data),
		.held_bg(held_bg), .held_bank(held_bank), .held_row(held_row),
		.held_col(held_col), .held_idx(held_idx), .tag(tag),
		.array_enable(array_enable), .array_type(array_type), .array_bg(array_bg),
		.array_bank(array_bank), .array_row(array_row), .array_col(array_col),
		.array_data(array_data), .array_index(array_index),
		.bank_valid(bank_valid), .bank_req(bank_req)
	);

endmodule

`default_nettype wire

//--- hdl/mc_pkg.sv
`default_nettype none

package mc_pkg;

	localparam int DATA_W = 32;
	localparam int ADDR_W = 30;
	localparam int ROW_W = 16;
	localparam int COL_W = 10;
	localparam int BANK_W = 2;
	localparam int BG_W = 2;
	localparam int TAG_W = 6; // both counters wrap at 64
	localparam int NUM_BANKS = 16;

	localparam int PERM_T = 5; // xor hash offset from the address top

	// the hash sources sit just below the row msb, offset by PERM_T
	localparam int HASH_BG_LO = ADDR_W - 1 - PERM_T + 2; // bits 27:26
	localparam int HASH_BANK_LO = ADDR_W - 1 - PERM_T; // bits 25:24

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [ROW_W-1:0] row_t;
	typedef logic [COL_W-1:0] col_t;
	typedef logic [BANK_W-1:0] bank_t;
	typedef logic [BG_W-1:0] bg_t;
	typedef logic [TAG_W-1:0] tag_t;

	typedef logic [BG_W+BANK_W-1:0] bank_idx_t; // {bg, bank}

	typedef logic [TAG_W+1+ROW_W-1:0] bank_word_t; // {tag, type, row}

	typedef enum logic {
		req_read,
		req_write
	} req_type_t;

	typedef enum logic [1:0] {
		st_idle,
		st_issue,
		st_stall
	} seq_state_t;

endpackage

`default_nettype wire

//--- hdl/req_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module req_sequencer import mc_pkg::*; (
	input wire clk,
	input wire rst,
	input wire in_valid,
	input wire held_valid,
	input wire req_type_t held_type,
	input wire bank_idx_t held_idx,
	input wire stop_reading,
	input wire stop_writing,
	input wire [NUM_BANKS-1:0] bank_busy,
	output logic load,
	output logic issue,
	output logic out_busy
);

	seq_state_t state;
	seq_state_t next_state;

	logic stopped; // array cannot take this type
	logic bank_hit; // target bank reports busy
	logic blocked;
	logic pending; // held request the fsm knows about

	always_comb begin
		if (held_type == req_write) begin
			stopped = stop_writing;
		end else begin
			stopped = stop_reading;
		end
	end

	assign bank_hit = bank_busy[held_idx]; // only the addressed bank matters
	assign blocked = stopped | bank_hit;

	// st_idle always coincides with an empty hold register
	assign pending = held_valid && (state != st_idle);

	always_comb begin
		issue = pending && !blocked;
		out_busy = pending && blocked;
		load = in_valid && !out_busy; // refill allowed on the issue cycle
	end

	always_comb begin
		next_state = state;
		case (state)
			st_idle: begin
				if (load) begin
					next_state = st_issue;
				end
			end
			st_issue: begin
				if (load) begin
					next_state = st_issue; // back to back flow
				end else if (blocked) begin
					next_state = st_stall;
				end else begin
					next_state = st_idle;
				end
			end
			st_stall: begin
				// stay until the stop level or the bank busy bit drops
				if (!blocked) begin
					if (load) begin
						next_state = st_issue;
					end else begin
						next_state = st_idle;
					end
				end
			end
			default: begin
				next_state = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			state <= next_state;
		end
	end

endmodule

`default_nettype wire

//--- hdl/tag_counter.sv
`timescale 1ns/1ps
`default_nettype none

module tag_counter import mc_pkg::*; (
	input wire clk,
	input wire rst,
	input wire advance,
	input wire req_type_t adv_type,
	output tag_t tag
);

	tag_t rd_cnt; // next read index
	tag_t wr_cnt; // next write index

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_cnt <= '0;
		end else if (advance && adv_type == req_read) begin
			rd_cnt <= rd_cnt + tag_t'(1); // wraps after 63
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_cnt <= '0;
		end else if (advance && adv_type == req_write) begin
			wr_cnt <= wr_cnt + tag_t'(1);
		end
	end

	// The tag reflects the count before this issue, so the first
	// request of each type goes out with index zero.
	always_comb begin
		if (adv_type == req_write) begin
			tag = wr_cnt;
		end else begin
			tag = rd_cnt;
		end
	end

endmodule

`default_nettype wire

//--- verification/mc_mapper_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mc_mapper_checker import mc_pkg::*; (
	input wire clk,
	input wire rst,
	input wire in_valid,
	input wire req_type_t in_type,
	input wire addr_t in_addr,
	input wire data_t in_data,
	input wire out_busy,
	input wire stop_reading,
	input wire stop_writing,
	input wire [NUM_BANKS-1:0] bank_busy,
	input wire array_enable,
	input wire req_type_t array_type,
	input wire [NUM_BANKS-1:0] bank_valid
);

	int unsigned fail_count = 0; // failed assertions so far

	a_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot(bank_valid) == array_enable)
	else begin
		$error("bank_valid is not one-hot exactly with array_enable");
		fail_count++;
	end

	a_stop_read: assert property (@(posedge clk) disable iff (rst)
		(array_enable && array_type == req_read) |-> !stop_reading)
	else begin
		$error("read issued while stop_reading was high");
		fail_count++;
	end

	a_stop_write: assert property (@(posedge clk) disable iff (rst)
		(array_enable && array_type == req_write) |-> !stop_writing)
	else begin
		$error("write issued while stop_writing was high");
		fail_count++;
	end

	a_bank_free: assert property (@(posedge clk) disable iff (rst)
		array_enable |-> (bank_valid & bank_busy) == '0)
	else begin
		$error("request issued to a busy bank");
		fail_count++;
	end

	// covers the reset cycles and the first cycle after
	a_reset_quiet: assert property (@(posedge clk)
		rst |=> (!out_busy && !array_enable && bank_valid == '0))
	else begin
		$error("outputs active during or right after reset");
		fail_count++;
	end

	a_host_hold: assert property (@(posedge clk) disable iff (rst)
		(in_valid && out_busy) |=>
			(in_valid && $stable(in_type) && $stable(in_addr) && $stable(in_data)))
	else begin
		$error("host request changed while out_busy was high");
		fail_count++;
	end

endmodule

`default_nettype wire

//--- verification/mc_mapper_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mc_mapper_tb import mc_pkg::*; ();

	localparam int NUM_RANDOM = 500;
	localparam int NUM_DIRECTED = 300; // mapping, tag, stop, busy and burst requests
	localparam int WATCHDOG_CYCLES = 2 * (NUM_RANDOM + NUM_DIRECTED) + 400;

	typedef struct packed {
		req_type_t typ;
		bg_t bg;
		bank_t bank;
		row_t row;
		col_t col;
		data_t data;
		tag_t tag;
	} expect_t;

	logic clk;
	logic rst;
	logic in_valid;
	req_type_t in_type;
	addr_t in_addr;
	data_t in_data;
	logic out_busy;
	logic stop_reading;
	logic stop_writing;
	logic array_enable;
	req_type_t array_type;
	bg_t array_bg;
	bank_t array_bank;
	row_t array_row;
	col_t array_col;
	data_t array_data;
	tag_t array_index;
	logic [NUM_BANKS-1:0] bank_busy;
	logic [NUM_BANKS-1:0] bank_valid;
	bank_word_t bank_req;

	expect_t exp_q[$]; // accepted, not yet issued
	tag_t model_rd_tag;
	tag_t model_wr_tag;
	string test_name;
	integer seed;
	logic levels_on; // random stop and busy levels running

	mc_mapper_top UUT (.*);

	bind mc_mapper_top mc_mapper_checker u_checker (
		.clk(clk), .rst(rst), .in_valid(in_valid), .in_type(in_type), .in_addr(in_addr),
		.in_data(in_data), .out_busy(out_busy), .stop_reading(stop_reading),
		.stop_writing(stop_writing), .bank_busy(bank_busy), .array_enable(array_enable),
		.array_type(array_type), .bank_valid(bank_valid)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk; // 20 ns period

	task automatic abort_run(input string why);
		$display("Test failed");
		$fatal(1, "%s", why);
	endtask

	task automatic report_mismatch(input string field, input logic [63:0] expected,
			input logic [63:0] actual);
		$display("Fail %s %s: expected %0h, actual %0h", test_name, field, expected, actual);
		abort_run("output value mismatch");
	endtask

	// reference mapping, written straight from the bank hash rule
	function automatic expect_t map_request(input req_type_t typ, input addr_t addr,
			input data_t data, input tag_t tag);
		expect_t e;
		e.typ = typ;
		e.bg = addr[5:4] ^ addr[27:26];
		e.bank = addr[13:12] ^ addr[25:24];
		e.row = addr[29:14];
		e.col = {addr[11:6], addr[3:0]};
		e.data = (typ == req_write) ? data : '0; // reads carry zero
		e.tag = tag;
		return e;
	endfunction

	task automatic check_issue(input expect_t e);
		logic [NUM_BANKS-1:0] exp_valid;
		bank_word_t exp_word;
		exp_valid = '0;
		exp_valid[{e.bg, e.bank}] = 1'b1;
		exp_word = {e.tag, e.typ, e.row};
		assert (array_type == e.typ) else report_mismatch("array_type", e.typ, array_type);
		assert (array_bg == e.bg) else report_mismatch("array_bg", e.bg, array_bg);
		assert (array_bank == e.bank) else report_mismatch("array_bank", e.bank, array_bank);
		assert (array_row == e.row) else report_mismatch("array_row", e.row, array_row);
		assert (array_col == e.col) else report_mismatch("array_col", e.col, array_col);
		assert (array_data == e.data) else report_mismatch("array_data", e.data, array_data);
		assert (array_index == e.tag) else report_mismatch("array_index", e.tag, array_index);
		assert (bank_valid == exp_valid) else report_mismatch("bank_valid", exp_valid, bank_valid);
		assert (bank_req == exp_word) else report_mismatch("bank_req", exp_word, bank_req);
	endtask

	// issue compare first, so a same edge accept lands behind the head
	always @(posedge clk) begin
		if (!rst && array_enable) begin
			if (exp_q.size() == 0) begin
				abort_run("issue seen with no accepted request outstanding");
			end else begin
				check_issue(exp_q.pop_front());
			end
		end
		if (!rst && in_valid && !out_busy) begin
			if (in_type == req_write) begin
				exp_q.push_back(map_request(in_type, in_addr, in_data, model_wr_tag));
				model_wr_tag++; // wraps after 63
			end else begin
				exp_q.push_back(map_request(in_type, in_addr, in_data, model_rd_tag));
				model_rd_tag++;
			end
		end
	end

	always @(UUT.u_checker.fail_count) begin
		if (UUT.u_checker.fail_count != 0) begin
			abort_run("bound protocol assertion failed");
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run("watchdog expired before all requests drained");
	end

	// returns on the edge that accepts the request, valid stays high
	task automatic send_req(input req_type_t typ, input addr_t addr, input data_t data);
		@(negedge clk);
		in_valid = 1'b1;
		in_type = typ;
		in_addr = addr;
		in_data = data;
		@(posedge clk);
		while (out_busy) @(posedge clk); // host holds its request
	endtask

	task automatic go_idle(input int cycles);
		@(negedge clk);
		in_valid = 1'b0;
		repeat (cycles) @(posedge clk);
	endtask

	// queues one more request behind a stalled one, then lifts every block
	task automatic release_after_stall(input string what, input req_type_t next_type,
			input addr_t next_addr);
		fork
			send_req(next_type, next_addr, 32'h7e57_0001);
			begin
				repeat (4) @(posedge clk);
				assert (out_busy) else abort_run(what);
				@(negedge clk);
				stop_reading = 1'b0;
				stop_writing = 1'b0;
				bank_busy = '0;
			end
		join
	endtask

	task automatic stop_check(input req_type_t stopped);
		req_type_t other;
		other = (stopped == req_read) ? req_write : req_read;
		@(negedge clk);
		stop_reading = (stopped == req_read);
		stop_writing = (stopped == req_write);
		send_req(other, 30'h0123_4567, 32'h1111_0000); // other type passes
		send_req(other, 30'h2ab0_0c30, 32'h2222_0000);
		send_req(stopped, 30'h1234_5678, 32'h3333_0000);
		release_after_stall("request not held while its stop level was high", other,
			30'h0fed_cba9);
		go_idle(2);
	endtask

	task automatic drive_levels();
		while (levels_on) begin
			@(negedge clk);
			stop_reading = ($random(seed) & 7) == 0;
			stop_writing = ($random(seed) & 7) == 0;
			bank_busy = NUM_BANKS'($random(seed) & $random(seed) &
				$random(seed) & $random(seed));
		end
		stop_reading = 1'b0;
		stop_writing = 1'b0;
		bank_busy = '0;
	endtask

	initial begin
		addr_t addr;
		data_t data;
		req_type_t typ;
		seed = 32'h28fe;
		rst = 1'b1;
		in_valid = 1'b0;
		in_type = req_read;
		in_addr = '0;
		in_data = '0;
		stop_reading = 1'b0;
		stop_writing = 1'b0;
		bank_busy = '0;
		model_rd_tag = '0;
		model_wr_tag = '0;
		levels_on = 1'b0;
		test_name = "reset";
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		test_name = "mapping";
		for (int i = 0; i < 32; i++) begin
			// second half sets row bits 13:10 so the hash flips bg and bank
			addr = {2'b01, (i >= 16) ? 4'b1101 : 4'b0000, 10'(i * 37), 2'(i), 6'(i * 5),
				2'(i >> 2), 4'(i + 3)};
			send_req((i % 2 == 1) ? req_write : req_read, addr, 32'hd000_0000 + i);
		end
		go_idle(2);

		test_name = "tags";
		for (int i = 0; i < 140; i++) begin
			send_req((i % 4 < 2) ? req_read : req_write, addr_t'(i * 4099), data_t'(i));
		end
		go_idle(2);

		test_name = "stop_reading";
		stop_check(req_read);
		test_name = "stop_writing";
		stop_check(req_write);

		test_name = "bank_busy";
		@(negedge clk);
		bank_busy = 16'hfffe; // all banks but 0
		send_req(req_write, 30'h0000_0000, 32'hcafe_0001);
		go_idle(2);
		@(negedge clk);
		bank_busy = 16'h0001;
		send_req(req_read, 30'h0500_1010, 32'h0); // hashes onto bank 0
		release_after_stall("request to a busy bank was not held", req_write, 30'h0000_1010);
		go_idle(2);

		test_name = "burst";
		for (int i = 0; i < 16; i++) begin
			send_req((i % 2 == 1) ? req_write : req_read, addr_t'(i * 70001), 32'h5a5a_0000 + i);
			if (i > 0) begin
				assert (array_enable) else abort_run("back-to-back request did not issue next cycle");
			end
		end
		go_idle(2);

		test_name = "random";
		levels_on = 1'b1;
		fork
			begin
				for (int i = 0; i < NUM_RANDOM; i++) begin
					typ = ($random(seed) & 1) ? req_write : req_read;
					addr = addr_t'($random(seed));
					data = $random(seed);
					send_req(typ, addr, data);
				end
				go_idle(1);
				levels_on = 1'b0;
			end
			drive_levels();
		join

		while (exp_q.size() != 0) @(posedge clk);
		repeat (2) @(posedge clk);
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire
